// File: include/trdb_opcodes.svh
// RISC-V branch and jump encodings

`ifndef TRDB_OPCODES_SVH
`define TRDB_OPCODES_SVH

// conditional branches, funct3 selects the compare
localparam logic [31:0] MASK_BEQ       = 32'h0000_707f;
localparam logic [31:0] MATCH_BEQ      = 32'h0000_0063;
localparam logic [31:0] MASK_BNE       = 32'h0000_707f;
localparam logic [31:0] MATCH_BNE      = 32'h0000_1063;
localparam logic [31:0] MASK_BLT       = 32'h0000_707f;
localparam logic [31:0] MATCH_BLT      = 32'h0000_4063;
localparam logic [31:0] MASK_BGE       = 32'h0000_707f;
localparam logic [31:0] MATCH_BGE      = 32'h0000_5063;
localparam logic [31:0] MASK_BLTU      = 32'h0000_707f;
localparam logic [31:0] MATCH_BLTU     = 32'h0000_6063;
localparam logic [31:0] MASK_BGEU      = 32'h0000_707f;
localparam logic [31:0] MATCH_BGEU     = 32'h0000_7063;

// immediate-compare branches use the two free funct3 slots
localparam logic [31:0] MASK_P_BEQIMM  = 32'h0000_707f;
localparam logic [31:0] MATCH_P_BEQIMM = 32'h0000_2063;
localparam logic [31:0] MASK_P_BNEIMM  = 32'h0000_707f;
localparam logic [31:0] MATCH_P_BNEIMM = 32'h0000_3063;

// targets a decoder cannot infer from the binary
localparam logic [31:0] MASK_JALR      = 32'h0000_707f;
localparam logic [31:0] MATCH_JALR     = 32'h0000_0067;
localparam logic [31:0] MASK_MRET      = 32'hffff_ffff;
localparam logic [31:0] MATCH_MRET     = 32'h3020_0073;
localparam logic [31:0] MASK_SRET      = 32'hffff_ffff;
localparam logic [31:0] MATCH_SRET     = 32'h1020_0073;
localparam logic [31:0] MASK_URET      = 32'hffff_ffff;
localparam logic [31:0] MATCH_URET     = 32'h0020_0073;

`endif

// File: hw/trdb_pkg.sv
// Trace encoder shared definitions

package trdb_pkg;

    localparam int unsigned XLEN     = 32;
    localparam int unsigned ILEN     = 32;
    localparam int unsigned CAUSELEN = 5;
    localparam int unsigned PRIVLEN  = 2;

    // the core comes out of reset in machine mode
    localparam logic [PRIVLEN-1:0] PRIV_M = 2'd3;

    // config register map
    localparam logic [1:0] CFG_CTRL  = 2'd0;
    localparam logic [1:0] CFG_LOWER = 2'd1;
    localparam logic [1:0] CFG_UPPER = 2'd2;

    localparam int unsigned CTRL_ENABLE_BIT = 0;
    localparam int unsigned CTRL_FILTER_BIT = 1;

    // branch map sizing
    localparam int unsigned BRANCH_MAP_MAX = 31;
    localparam int unsigned BRANCH_CNT_W   = 5;

    `include "trdb_opcodes.svh"

    typedef enum logic [1:0] {
        FMT_ADDR        = 2'd0,
        FMT_EXCEPTION   = 2'd1,
        FMT_BRANCH_FULL = 2'd2
    } trdb_format_e;

    // one retired instruction as seen at the core boundary
    typedef struct packed {
        logic                valid;
        logic                exception;
        logic [CAUSELEN-1:0] cause;
        logic [PRIVLEN-1:0]  priv;
        logic [XLEN-1:0]     iaddr;
        logic [ILEN-1:0]     instr;
        logic                compressed;
    } retire_t;

    typedef struct packed {
        logic            enable;
        logic            filter_en;
        logic [XLEN-1:0] lower;
        logic [XLEN-1:0] upper;
    } trace_cfg_t;

    // view of the "this" instruction together with its neighbours
    typedef struct packed {
        logic [XLEN-1:0]     address;
        logic [CAUSELEN-1:0] cause;
        logic [PRIVLEN-1:0]  priv;
        logic                qualified;
        logic                first_qualified;
        logic                is_branch;
        logic                branch_taken;
        logic                exception;
        logic                last_exception;
        logic                last_discontinuity;
        logic                next_unqualified;
        logic                priv_change;
    } phase_t;

    typedef struct packed {
        trdb_format_e              format;
        logic [BRANCH_CNT_W-1:0]   branch_cnt;
        logic [BRANCH_MAP_MAX-1:0] branch_map;
        logic [XLEN-1:0]           address;
        logic [CAUSELEN-1:0]       cause;
        logic [PRIVLEN-1:0]        priv;
    } packet_t;

endpackage

// File: hw/trdb_cfg_regs.sv
// Trace configuration registers

module trdb_cfg_regs
    import trdb_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,

    input  logic            cfg_we_i,
    input  logic [1:0]      cfg_addr_i,
    input  logic [XLEN-1:0] cfg_wdata_i,
    output logic [XLEN-1:0] cfg_rdata_o,

    output trace_cfg_t      cfg_o
);

    // only the enable and filter bits of the control word exist
    logic [CTRL_FILTER_BIT:0] ctrl_q;
    logic [XLEN-1:0]          lower_q;
    logic [XLEN-1:0]          upper_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q  <= '0;
            lower_q <= '0;
            upper_q <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_CTRL:  ctrl_q  <= cfg_wdata_i[CTRL_FILTER_BIT:0];
                CFG_LOWER: lower_q <= cfg_wdata_i;
                CFG_UPPER: upper_q <= cfg_wdata_i;
                default:   ;
            endcase
        end
    end

    // read-back, unmapped address and unused control bits give zero
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            CFG_CTRL:  cfg_rdata_o[CTRL_FILTER_BIT:0] = ctrl_q;
            CFG_LOWER: cfg_rdata_o = lower_q;
            CFG_UPPER: cfg_rdata_o = upper_q;
            default:   cfg_rdata_o = '0;
        endcase
    end

    always_comb begin
        cfg_o.enable    = ctrl_q[CTRL_ENABLE_BIT];
        cfg_o.filter_en = ctrl_q[CTRL_FILTER_BIT];
        cfg_o.lower     = lower_q;
        cfg_o.upper     = upper_q;
    end

endmodule

// File: hw/trdb_retire_pipe.sv
// Retired instruction pipeline

module trdb_retire_pipe
    import trdb_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  retire_t    retire_i,
    input  trace_cfg_t cfg_i,

    output logic       step_o,
    output phase_t     phase_o
);

    // registered core inputs, this is the next stage
    retire_t retire_q;

    logic nc_in_range;
    logic nc_qualified;
    logic nc_is_branch;
    logic nc_discontinuity;

    // this stage
    logic                tc_qualified;
    logic                tc_exception;
    logic                tc_is_branch;
    logic                tc_discontinuity;
    logic [PRIVLEN-1:0]  tc_priv;
    logic [XLEN-1:0]     tc_iaddr;
    logic [CAUSELEN-1:0] tc_cause;
    logic                tc_compressed;
    logic [XLEN-1:0]     tc_seq_iaddr;

    // last stage
    logic lc_qualified;
    logic lc_exception;
    logic lc_discontinuity;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_q <= '0;
        end else begin
            retire_q <= retire_i;
        end
    end

    // qualification is decided once, when the instruction enters
    always_comb begin
        nc_in_range  = (retire_q.iaddr >= cfg_i.lower) && (retire_q.iaddr <= cfg_i.upper);
        nc_qualified = cfg_i.enable && (!cfg_i.filter_en || nc_in_range);
    end

    // beq, bne, blt, bge, bltu, bgeu and the two immediate compares
    always_comb begin
        nc_is_branch = ((retire_q.instr & MASK_BEQ)      == MATCH_BEQ)      ||
                       ((retire_q.instr & MASK_BNE)      == MATCH_BNE)      ||
                       ((retire_q.instr & MASK_BLT)      == MATCH_BLT)      ||
                       ((retire_q.instr & MASK_BGE)      == MATCH_BGE)      ||
                       ((retire_q.instr & MASK_BLTU)     == MATCH_BLTU)     ||
                       ((retire_q.instr & MASK_BGEU)     == MATCH_BGEU)     ||
                       ((retire_q.instr & MASK_P_BEQIMM) == MATCH_P_BEQIMM) ||
                       ((retire_q.instr & MASK_P_BNEIMM) == MATCH_P_BNEIMM);
    end

    // jalr and the trap returns
    always_comb begin
        nc_discontinuity = ((retire_q.instr & MASK_JALR) == MATCH_JALR) ||
                           ((retire_q.instr & MASK_MRET) == MATCH_MRET) ||
                           ((retire_q.instr & MASK_SRET) == MATCH_SRET) ||
                           ((retire_q.instr & MASK_URET) == MATCH_URET);
    end

    // stages only move when a new valid instruction shows up
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_qualified     <= 1'b0;
            tc_exception     <= 1'b0;
            tc_is_branch     <= 1'b0;
            tc_discontinuity <= 1'b0;
            tc_priv          <= PRIV_M;
            lc_qualified     <= 1'b0;
            lc_exception     <= 1'b0;
            lc_discontinuity <= 1'b0;
        end else if (retire_q.valid) begin
            tc_qualified     <= nc_qualified;
            tc_exception     <= retire_q.exception;
            tc_is_branch     <= nc_is_branch;
            tc_discontinuity <= nc_discontinuity;
            tc_priv          <= retire_q.priv;
            lc_qualified     <= tc_qualified;
            lc_exception     <= tc_exception;
            lc_discontinuity <= tc_discontinuity;
        end
    end

    always_ff @(posedge clk_i) begin
        if (retire_q.valid) begin
            tc_iaddr      <= retire_q.iaddr;
            tc_cause      <= retire_q.cause;
            tc_compressed <= retire_q.compressed;
        end
    end

    // fall-through address of the this instruction
    assign tc_seq_iaddr = tc_iaddr + (tc_compressed ? XLEN'(2) : XLEN'(4));

    // the this instruction is complete once its successor is known
    assign step_o = retire_q.valid && tc_qualified;

    always_comb begin
        phase_o.address            = tc_iaddr;
        phase_o.cause              = tc_cause;
        phase_o.priv               = tc_priv;
        phase_o.qualified          = tc_qualified;
        phase_o.first_qualified    = tc_qualified && !lc_qualified;
        phase_o.is_branch          = tc_is_branch;
        phase_o.branch_taken       = (retire_q.iaddr != tc_seq_iaddr);
        phase_o.exception          = tc_exception;
        phase_o.last_exception     = lc_exception;
        phase_o.last_discontinuity = lc_discontinuity;
        phase_o.next_unqualified   = !nc_qualified;
        phase_o.priv_change        = (retire_q.priv != tc_priv);
    end

endmodule

// File: hw/trdb_branch_map.sv
// Branch map accumulator

module trdb_branch_map
    import trdb_pkg::*;
#(
    parameter int unsigned BRANCH_MAP_LEN = 31
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      valid_i,
    input  logic                      taken_i,
    input  logic                      flush_i,

    output logic [BRANCH_MAP_MAX-1:0] map_o,
    output logic [BRANCH_CNT_W-1:0]   count_o,
    output logic                      full_o
);

    logic [BRANCH_MAP_MAX-1:0] map_q;
    logic [BRANCH_MAP_MAX-1:0] map_d;
    logic [BRANCH_CNT_W-1:0]   count_q;
    logic [BRANCH_CNT_W-1:0]   count_d;

    // the current branch is visible in the same cycle
    always_comb begin
        map_d   = map_q;
        count_d = count_q;
        if (valid_i) begin
            map_d[count_q] = taken_i;
            count_d        = count_q + BRANCH_CNT_W'(1);
        end
    end

    assign map_o   = map_d;
    assign count_o = count_d;
    assign full_o  = (count_d == BRANCH_CNT_W'(BRANCH_MAP_LEN));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_d;
            count_q <= count_d;
        end
    end

endmodule

// File: hw/trdb_packet_gen.sv
// Packet priority and assembly

module trdb_packet_gen
    import trdb_pkg::*;
#(
    parameter int unsigned BRANCH_MAP_LEN = 31
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      step_i,
    input  phase_t                    phase_i,

    input  logic [BRANCH_MAP_MAX-1:0] map_i,
    input  logic [BRANCH_CNT_W-1:0]   count_i,
    input  logic                      full_i,
    output logic                      flush_o,

    output packet_t                   packet_o,
    output logic                      packet_valid_o
);

    // map bits beyond the configured length stay zero
    localparam logic [BRANCH_MAP_MAX-1:0] MAP_MASK =
        {BRANCH_MAP_MAX{1'b1}} >> (BRANCH_MAP_MAX - BRANCH_MAP_LEN);

    logic         need_addr;
    logic         emit;
    trdb_format_e fmt;
    packet_t      packet_d;
    packet_t      packet_q;
    logic         packet_valid_q;

    // any of these leaves the decoder unable to follow the program
    always_comb begin
        need_addr = phase_i.first_qualified    ||
                    phase_i.last_exception     ||
                    phase_i.last_discontinuity ||
                    phase_i.next_unqualified   ||
                    phase_i.priv_change;
        emit      = step_i && (phase_i.exception || need_addr || full_i);
    end

    // exception beats address, address beats a full map
    always_comb begin
        if (phase_i.exception) begin
            fmt = FMT_EXCEPTION;
        end else if (need_addr) begin
            fmt = FMT_ADDR;
        end else begin
            fmt = FMT_BRANCH_FULL;
        end
    end

    always_comb begin
        packet_d.format     = fmt;
        packet_d.branch_cnt = count_i;
        packet_d.branch_map = map_i & MAP_MASK;
        packet_d.priv       = phase_i.priv;
        // a full map packet carries no address
        packet_d.address    = (fmt == FMT_BRANCH_FULL) ? '0 : phase_i.address;
        packet_d.cause      = (fmt == FMT_EXCEPTION) ? phase_i.cause : '0;
    end

    // every emitted packet takes the map with it
    assign flush_o = emit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_q <= 1'b0;
        end else begin
            packet_valid_q <= emit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (emit) begin
            packet_q <= packet_d;
        end
    end

    assign packet_o       = packet_q;
    assign packet_valid_o = packet_valid_q;

endmodule

// File: hw/trace_debugger.sv
// RISC-V instruction trace encoder

module trace_debugger
    import trdb_pkg::*;
#(
    parameter int unsigned BRANCH_MAP_LEN = 31
) (
    input  logic            clk_i,
    input  logic            rst_ni,

    input  retire_t         retire_i,

    input  logic            cfg_we_i,
    input  logic [1:0]      cfg_addr_i,
    input  logic [XLEN-1:0] cfg_wdata_i,
    output logic [XLEN-1:0] cfg_rdata_o,

    output packet_t         packet_o,
    output logic            packet_valid_o
);

    trace_cfg_t                cfg;
    logic                      step;
    phase_t                    phase;
    logic [BRANCH_MAP_MAX-1:0] map;
    logic [BRANCH_CNT_W-1:0]   count;
    logic                      full;
    logic                      flush;

    trdb_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (cfg)
    );

    trdb_retire_pipe u_retire_pipe (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .retire_i (retire_i),
        .cfg_i    (cfg),
        .step_o   (step),
        .phase_o  (phase)
    );

    // only qualified branches enter the map
    trdb_branch_map #(
        .BRANCH_MAP_LEN (BRANCH_MAP_LEN)
    ) u_branch_map (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (step && phase.is_branch),
        .taken_i (phase.branch_taken),
        .flush_i (flush),
        .map_o   (map),
        .count_o (count),
        .full_o  (full)
    );

    trdb_packet_gen #(
        .BRANCH_MAP_LEN (BRANCH_MAP_LEN)
    ) u_packet_gen (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .step_i         (step),
        .phase_i        (phase),
        .map_i          (map),
        .count_i        (count),
        .full_i         (full),
        .flush_o        (flush),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o)
    );

endmodule

// File: verif/trdb_properties.sv
// Trace encoder assertions

module trdb_properties
    import trdb_pkg::*;
#(
    parameter int unsigned BRANCH_MAP_LEN = 31
) (
    input logic    clk_i,
    input logic    rst_ni,
    input retire_t retire_i,
    input packet_t packet_o,
    input logic    packet_valid_o
);

    // number of assertion failures so far
    int fail_count = 0;

    // input register plus the step stage come before every packet
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> $past(retire_i.valid, 2))
        else begin
            $error("packet without a valid instruction two cycles earlier");
            fail_count++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> (packet_o.branch_cnt <= BRANCH_MAP_LEN))
        else begin
            $error("branch count above the map length");
            fail_count++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (packet_valid_o && packet_o.format == FMT_BRANCH_FULL) |->
            (packet_o.branch_cnt == BRANCH_MAP_LEN))
        else begin
            $error("full map packet with a short branch count");
            fail_count++;
        end

    assert property (@(posedge clk_i) !rst_ni |-> !packet_valid_o)
        else begin
            $error("packet strobe high during reset");
            fail_count++;
        end

endmodule

bind trace_debugger trdb_properties #(
    .BRANCH_MAP_LEN (BRANCH_MAP_LEN)
) u_trdb_properties (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .retire_i       (retire_i),
    .packet_o       (packet_o),
    .packet_valid_o (packet_valid_o)
);

// File: verif/tb_trace_debugger.sv
// Trace encoder testbench

module tb_trace_debugger
    import trdb_pkg::*;
();

    localparam int unsigned BRANCH_MAP_LEN = 8;
    localparam int MAX_GAP = 4;
    localparam int N_INSTR = 200;
    // five trace tests, each with one extra instruction to drain
    localparam int TOTAL_INSTR = 5 * (N_INSTR + 1);
    localparam longint WATCHDOG_TIME = (TOTAL_INSTR * (MAX_GAP + 1) + 2000) * 20;

    // one instruction as the reference model remembers it
    typedef struct packed {
        logic                qual;
        logic                exc;
        logic                disc;
        logic                branch;
        logic                comp;
        logic [PRIVLEN-1:0]  priv;
        logic [CAUSELEN-1:0] cause;
        logic [XLEN-1:0]     addr;
    } mdl_instr_t;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    retire_t         retire_i;
    logic            cfg_we_i;
    logic [1:0]      cfg_addr_i;
    logic [XLEN-1:0] cfg_wdata_i;
    logic [XLEN-1:0] cfg_rdata_o;
    packet_t         packet_o;
    logic            packet_valid_o;

    logic [31:0]               rng;
    packet_t                   exp_q[$];
    packet_t                   exp_pkt;
    mdl_instr_t                this_i;
    mdl_instr_t                last_i;
    logic [BRANCH_MAP_MAX-1:0] m_map;
    int                        m_cnt;
    logic [XLEN-1:0]           m_regs [4];
    logic [XLEN-1:0]           pc;
    logic [PRIVLEN-1:0]        priv;
    int error_count;
    int tests_passed;
    int tests_failed;
    int checked;

    trace_debugger #(
        .BRANCH_MAP_LEN (BRANCH_MAP_LEN)
    ) u_trace_debugger (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .retire_i       (retire_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic qualifies(input logic [XLEN-1:0] addr);
        return m_regs[CFG_CTRL][CTRL_ENABLE_BIT] && (!m_regs[CFG_CTRL][CTRL_FILTER_BIT] ||
               (addr >= m_regs[CFG_LOWER] && addr <= m_regs[CFG_UPPER]));
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // the previous instruction completes once its successor n is known
    task automatic model_step(input mdl_instr_t n);
        logic    taken;
        logic    need_addr;
        logic    full;
        packet_t p;
        if (this_i.qual) begin
            taken = (n.addr != this_i.addr + (this_i.comp ? XLEN'(2) : XLEN'(4)));
            if (this_i.branch) begin
                m_map[m_cnt] = taken;
                m_cnt++;
            end
            need_addr = !last_i.qual || last_i.exc || last_i.disc || !n.qual ||
                        (n.priv != this_i.priv);
            full = (m_cnt == BRANCH_MAP_LEN);
            p = '0;
            p.branch_cnt = BRANCH_CNT_W'(m_cnt);
            p.branch_map = m_map;
            p.priv       = this_i.priv;
            p.address    = this_i.addr;
            if (this_i.exc) begin
                p.format = FMT_EXCEPTION;
                p.cause  = this_i.cause;
            end else if (need_addr) begin
                p.format = FMT_ADDR;
            end else if (full) begin
                p.format  = FMT_BRANCH_FULL;
                p.address = '0;
            end
            if (this_i.exc || need_addr || full) begin
                exp_q.push_back(p);
                m_map = '0;
                m_cnt = 0;
            end
        end
        last_i = this_i;
        this_i = n;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [XLEN-1:0] data);
        @(posedge clk_i);
        retire_i.valid <= 1'b0;
        cfg_we_i       <= 1'b1;
        cfg_addr_i     <= addr;
        cfg_wdata_i    <= data;
        @(posedge clk_i);
        cfg_we_i       <= 1'b0;
        m_regs[addr] = (addr == CFG_CTRL) ? (data & 32'h3) : (addr == 2'd3) ? '0 : data;
    endtask

    task automatic send_instr(input logic exc_en, input logic disc_en, input logic priv_en);
        mdl_instr_t      n;
        retire_t         rt;
        logic [31:0]     r;
        logic [31:0]     w;
        logic [XLEN-1:0] fall;
        logic [XLEN-1:0] target;
        int              kind;
        r = next_random();
        w = next_random();
        kind = r[4:2];
        repeat (r[31:28] % MAX_GAP) begin
            @(posedge clk_i);
            retire_i.valid <= 1'b0;
        end
        if (priv_en && r[16:14] == 3'd0) begin
            priv = r[17] ? PRIV_M : {1'b0, r[18]};
        end
        n.branch = (kind <= 2);
        n.disc   = disc_en && (kind == 3 || kind == 4);
        n.comp   = r[5];
        n.exc    = exc_en && (r[8:6] == 3'd0);
        n.cause  = r[13:9];
        n.priv   = priv;
        n.addr   = pc;
        n.qual   = qualifies(pc);
        rt.valid      = 1'b1;
        rt.exception  = n.exc;
        rt.cause      = n.cause;
        rt.priv       = n.priv;
        rt.iaddr      = n.addr;
        rt.compressed = n.comp;
        if (n.branch) begin
            rt.instr = {w[31:7], 7'h63};
        end else if (n.disc && kind == 3) begin
            rt.instr = {w[31:15], 3'b000, w[11:7], 7'h67};
        end else if (n.disc) begin
            rt.instr = MATCH_MRET;
        end else begin
            rt.instr = {w[31:7], 7'h13};
        end
        // next pc, kept inside the 0x1000 to 0x1fff window
        fall   = pc + (n.comp ? XLEN'(2) : XLEN'(4));
        target = 32'h1000 + XLEN'({w[22:12], 1'b0});
        if (n.exc || n.disc) begin
            pc = target;
        end else if (n.branch && r[19]) begin
            pc = (target == fall) ? target + XLEN'(8) : target;
        end else begin
            pc = fall;
        end
        @(posedge clk_i);
        retire_i <= rt;
        model_step(n);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        write_cfg(CFG_CTRL, '0);
        send_instr(1'b0, 1'b0, 1'b0);
        @(posedge clk_i);
        retire_i.valid <= 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (3) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            $display("%0d expected packets never came out of the DUT", exp_q.size());
            error_count++;
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok, %0d packets checked", name, checked);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
        checked = 0;
    endtask

    task automatic check_config();
        int          errs_before;
        logic [31:0] r;
        errs_before = error_count;
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            write_cfg(r[1:0], next_random());
            for (int a = 0; a < 4; a++) begin
                @(posedge clk_i);
                cfg_addr_i <= a[1:0];
                @(negedge clk_i);
                check_field("cfg_rdata_o", cfg_rdata_o, m_regs[a]);
            end
        end
        write_cfg(CFG_CTRL, '0);
        report_test("config_readback", errs_before);
    endtask

    task automatic run_trace(input string name, input logic [XLEN-1:0] ctrl,
                             input logic exc_en, input logic disc_en, input logic priv_en);
        int errs_before;
        errs_before = error_count;
        write_cfg(CFG_CTRL, ctrl);
        repeat (N_INSTR) send_instr(exc_en, disc_en, priv_en);
        drain();
        report_test(name, errs_before);
    endtask

    // packets are compared at the falling edge, away from the register updates
    always @(negedge clk_i) begin
        if (rst_ni && packet_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("DUT emitted a packet that the model did not expect");
                error_count++;
            end else begin
                exp_pkt = exp_q.pop_front();
                checked++;
                check_field("packet_o.format", 32'(packet_o.format), 32'(exp_pkt.format));
                check_field("packet_o.branch_cnt", 32'(packet_o.branch_cnt),
                            32'(exp_pkt.branch_cnt));
                check_field("packet_o.branch_map", 32'(packet_o.branch_map),
                            32'(exp_pkt.branch_map));
                check_field("packet_o.address", packet_o.address, exp_pkt.address);
                check_field("packet_o.cause", 32'(packet_o.cause), 32'(exp_pkt.cause));
                check_field("packet_o.priv", 32'(packet_o.priv), 32'(exp_pkt.priv));
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rng          = 32'h8d2da210;
        rst_ni       = 1'b0;
        retire_i     = '0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = '0;
        cfg_wdata_i  = '0;
        this_i       = '0;
        this_i.priv  = PRIV_M;
        last_i       = '0;
        m_map        = '0;
        m_cnt        = 0;
        m_regs       = '{default: '0};
        pc           = 32'h1000;
        priv         = PRIV_M;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        checked      = 0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        check_config();
        run_trace("sequential_branches", 32'h1, 1'b0, 1'b0, 1'b0);
        run_trace("exceptions", 32'h1, 1'b1, 1'b0, 1'b0);
        run_trace("discontinuities_priv", 32'h1, 1'b0, 1'b1, 1'b1);
        write_cfg(CFG_LOWER, 32'h1400);
        write_cfg(CFG_UPPER, 32'h1bff);
        run_trace("range_filter", 32'h3, 1'b1, 1'b1, 1'b0);
        run_trace("tracing_disabled", 32'h0, 1'b1, 1'b1, 1'b1);

        if (u_trace_debugger.u_trdb_properties.fail_count != 0) begin
            $display("%0d bound assertions failed during the run",
                     u_trace_debugger.u_trdb_properties.fail_count);
            error_count += u_trace_debugger.u_trdb_properties.fail_count;
        end

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
hw/trdb_pkg.sv
hw/trdb_cfg_regs.sv
hw/trdb_retire_pipe.sv
hw/trdb_branch_map.sv
hw/trdb_packet_gen.sv
hw/trace_debugger.sv
verif/trdb_properties.sv
verif/tb_trace_debugger.sv

// File: Bender.yml
package:
  name: trace_debugger

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/trdb_pkg.sv
      - hw/trdb_cfg_regs.sv
      - hw/trdb_retire_pipe.sv
      - hw/trdb_branch_map.sv
      - hw/trdb_packet_gen.sv
      - hw/trace_debugger.sv
  - target: test
    files:
      - verif/trdb_properties.sv
      - verif/tb_trace_debugger.sv
